// File: board_pkg.sv
package board_pkg;

    // Board geometry
    localparam int NUM_CARDS   = 12;
    localparam int NUM_PAIRS   = 6;
    localparam int CARD_ADDR_W = 4;
    localparam int PAIRS_W     = $clog2(NUM_PAIRS + 1);

    // 4 bits per channel for red, green and blue
    localparam int COLOR_W = 12;

    // Card state as seen by the display side
    typedef enum logic [1:0] {
        CARD_HIDDEN  = 2'b01,
        CARD_REMOVED = 2'b10,
        CARD_SHOWN   = 2'b11
    } card_status_t;

    typedef struct packed {
        card_status_t       status;
        logic [COLOR_W-1:0] color;
    } card_view_t;

endpackage

// File: game_pkg.sv
package game_pkg;

    import board_pkg::*;

    // Short waits, sized for simulation
    localparam int SHOW_WAIT_CYCLES  = 8;
    localparam int JUDGE_WAIT_CYCLES = 16;
    localparam int WAIT_W            = $clog2(JUDGE_WAIT_CYCLES + 1);

    // Command queue depth must stay a power of two
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    typedef enum logic [2:0] {
        PH_IDLE        = 3'd0,
        PH_DEAL        = 3'd1,
        PH_WAIT_FIRST  = 3'd2,
        PH_WAIT_SECOND = 3'd3,
        PH_JUDGE       = 3'd4,
        PH_APPLY       = 3'd5,
        PH_GAME_OVER   = 3'd6
    } game_phase_t;

    // One write to the board
    typedef struct packed {
        logic [CARD_ADDR_W-1:0] addr;
        card_status_t           status;
    } card_cmd_t;

endpackage

// File: game_fsm.sv
`timescale 1ns/100ps

module game_fsm
    import board_pkg::*, game_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   deal_done,
    input  logic                   click_valid,
    input  logic [CARD_ADDR_W-1:0] click_addr,
    output logic                   click_ready,
    input  card_view_t             lookup_view,
    output logic [CARD_ADDR_W-1:0] lookup_addr,
    output logic                   cmd_valid,
    output card_cmd_t              cmd,
    input  logic                   cmd_ready,
    output logic                   dealing,
    output logic [PAIRS_W-1:0]     pairs_left,
    output logic                   game_over
);

    game_phase_t                     phase, phase_nxt;
    logic [WAIT_W-1:0]               wait_cnt, wait_cnt_nxt;
    logic [1:0]                      issued, issued_nxt;
    logic [PAIRS_W-1:0]              pairs_left_nxt;
    logic                            game_over_nxt;
    logic                            cmd_valid_nxt;
    card_cmd_t                       cmd_nxt;
    logic [1:0][CARD_ADDR_W-1:0]     pick_addr, pick_addr_nxt;
    logic [1:0][COLOR_W-1:0]         pick_color, pick_color_nxt;
    logic                            second_pick;
    logic                            click_fire;
    logic                            click_hidden;
    logic                            colors_match;

    assign dealing      = (phase == PH_DEAL);
    assign second_pick  = (phase == PH_WAIT_SECOND);
    assign click_ready  = (phase == PH_WAIT_FIRST || second_pick) && (wait_cnt == '0)
                          && !cmd_valid;
    assign click_fire   = click_valid && click_ready;
    assign lookup_addr  = click_addr;
    assign click_hidden = (lookup_view.status == CARD_HIDDEN);
    assign colors_match = (pick_color[0] == pick_color[1]);

    //////////////////////////////////////////////////////////////////////
    // State registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            phase      <= PH_IDLE;
            wait_cnt   <= '0;
            issued     <= '0;
            pairs_left <= PAIRS_W'(NUM_PAIRS);
            game_over  <= 1'b0;
            cmd_valid  <= 1'b0;
        end else begin
            phase      <= phase_nxt;
            wait_cnt   <= wait_cnt_nxt;
            issued     <= issued_nxt;
            pairs_left <= pairs_left_nxt;
            game_over  <= game_over_nxt;
            cmd_valid  <= cmd_valid_nxt;
        end
    end

    // Picked cards and outgoing command
    always_ff @(posedge clk) begin
        cmd        <= cmd_nxt;
        pick_addr  <= pick_addr_nxt;
        pick_color <= pick_color_nxt;
    end

    //////////////////////////////////////////////////////////////////////
    // Next-state logic
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        phase_nxt      = phase;
        wait_cnt_nxt   = wait_cnt;
        issued_nxt     = issued;
        pairs_left_nxt = pairs_left;
        game_over_nxt  = game_over;
        cmd_valid_nxt  = cmd_valid && !cmd_ready;
        cmd_nxt        = cmd;
        pick_addr_nxt  = pick_addr;
        pick_color_nxt = pick_color;

        case (phase)
            PH_IDLE, PH_GAME_OVER: begin
                if (start) begin
                    phase_nxt      = PH_DEAL;
                    game_over_nxt  = 1'b0;
                    pairs_left_nxt = PAIRS_W'(NUM_PAIRS);
                end
            end

            PH_DEAL: begin
                if (deal_done) begin
                    phase_nxt    = PH_WAIT_FIRST;
                    wait_cnt_nxt = WAIT_W'(SHOW_WAIT_CYCLES);
                end
            end

            // Both picks share this handling and second_pick selects the slot
            PH_WAIT_FIRST, PH_WAIT_SECOND: begin
                if (wait_cnt != '0) begin
                    wait_cnt_nxt = wait_cnt - 1'b1;
                end
                if (click_fire && click_hidden) begin
                    cmd_valid_nxt               = 1'b1;
                    cmd_nxt.addr                = click_addr;
                    cmd_nxt.status              = CARD_SHOWN;
                    pick_addr_nxt[second_pick]  = click_addr;
                    pick_color_nxt[second_pick] = lookup_view.color;
                    if (second_pick) begin
                        phase_nxt    = PH_JUDGE;
                        wait_cnt_nxt = WAIT_W'(JUDGE_WAIT_CYCLES);
                    end else begin
                        phase_nxt    = PH_WAIT_SECOND;
                        wait_cnt_nxt = WAIT_W'(SHOW_WAIT_CYCLES);
                    end
                end
            end

            PH_JUDGE: begin
                if (wait_cnt != '0) begin
                    wait_cnt_nxt = wait_cnt - 1'b1;
                end else if (!cmd_valid) begin
                    issued_nxt = '0;
                    phase_nxt  = PH_APPLY;
                end
            end

            PH_APPLY: begin
                if (issued != 2'd2) begin
                    // Next command as soon as the output slot frees up
                    if (!cmd_valid || cmd_ready) begin
                        cmd_valid_nxt  = 1'b1;
                        cmd_nxt.addr   = pick_addr[issued[0]];
                        cmd_nxt.status = colors_match ? CARD_REMOVED : CARD_HIDDEN;
                        issued_nxt     = issued + 1'b1;
                    end
                end else if (cmd_valid) begin
                    // Last command still waiting so the drain time starts over
                    wait_cnt_nxt = WAIT_W'(FIFO_DEPTH);
                end else if (wait_cnt != '0) begin
                    wait_cnt_nxt = wait_cnt - 1'b1;
                end else begin
                    if (colors_match) begin
                        pairs_left_nxt = pairs_left - 1'b1;
                    end
                    if (colors_match && pairs_left == PAIRS_W'(1)) begin
                        phase_nxt     = PH_GAME_OVER;
                        game_over_nxt = 1'b1;
                    end else begin
                        phase_nxt    = PH_WAIT_FIRST;
                        wait_cnt_nxt = WAIT_W'(SHOW_WAIT_CYCLES);
                    end
                end
            end

            default: begin
                phase_nxt = PH_IDLE;
            end
        endcase
    end

endmodule

// File: card_cmd_fifo.sv
`timescale 1ns/100ps

module card_cmd_fifo
    import game_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  card_cmd_t in_cmd,
    output logic      in_ready,
    output logic      out_valid,
    output card_cmd_t out_cmd,
    input  logic      out_ready
);

    card_cmd_t               slots [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0]   wr_ptr;
    logic [FIFO_PTR_W-1:0]   rd_ptr;
    logic [FIFO_PTR_W:0]     count;
    logic                    full;
    logic                    empty;
    logic                    push;
    logic                    pop;

    // Depth is a power of two, so the top count bit means full
    assign full      = count[FIFO_PTR_W];
    assign empty     = (count == '0);
    assign in_ready  = !full;
    assign out_valid = !empty;
    assign out_cmd   = slots[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= in_cmd;
        end
    end

endmodule

// File: card_board.sv
`timescale 1ns/100ps

module card_board
    import board_pkg::*, game_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dealing,
    input  logic                   deal_valid,
    input  logic [COLOR_W-1:0]     deal_color,
    output logic                   deal_ready,
    output logic                   deal_done,
    input  logic                   cmd_valid,
    input  card_cmd_t              cmd,
    output logic                   cmd_ready,
    input  logic [CARD_ADDR_W-1:0] lookup_addr,
    output card_view_t             lookup_view,
    input  logic [CARD_ADDR_W-1:0] view_addr,
    output card_view_t             view
);

    card_status_t           status_q [NUM_CARDS];
    logic [COLOR_W-1:0]     color_q  [NUM_CARDS];
    logic [CARD_ADDR_W-1:0] deal_addr;
    logic                   deal_fire;
    logic                   cmd_fire;

    // Addresses past the last card read as removed
    function automatic card_view_t read_card(input logic [CARD_ADDR_W-1:0] addr);
        card_view_t v;
        if (addr < NUM_CARDS) begin
            v.status = status_q[addr];
            v.color  = color_q[addr];
        end else begin
            v.status = CARD_REMOVED;
            v.color  = '0;
        end
        return v;
    endfunction

    assign deal_ready = dealing && (deal_addr != CARD_ADDR_W'(NUM_CARDS));
    assign deal_fire  = deal_valid && deal_ready;
    assign cmd_ready  = !dealing;
    assign cmd_fire   = cmd_valid && cmd_ready;

    //////////////////////////////////////////////////////////////////////
    // Deal loading and command execution
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CARDS; i++) begin
                status_q[i] <= CARD_REMOVED;
            end
            deal_addr <= '0;
            deal_done <= 1'b0;
        end else begin
            deal_done <= deal_fire && (deal_addr == CARD_ADDR_W'(NUM_CARDS - 1));
            if (!dealing) begin
                deal_addr <= '0;
            end else if (deal_fire) begin
                deal_addr <= deal_addr + 1'b1;
            end
            if (deal_fire) begin
                status_q[deal_addr] <= CARD_HIDDEN;
            end
            if (cmd_fire && cmd.addr < NUM_CARDS) begin
                status_q[cmd.addr] <= cmd.status;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (deal_fire) begin
            color_q[deal_addr] <= deal_color;
        end
    end

    // Machine lookup and display read
    always_comb begin
        lookup_view = read_card(lookup_addr);
        view        = read_card(view_addr);
    end

endmodule

// File: memory_game_top.sv
`timescale 1ns/100ps

module memory_game_top
    import board_pkg::*, game_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   deal_valid,
    input  logic [COLOR_W-1:0]     deal_color,
    output logic                   deal_ready,
    input  logic                   click_valid,
    input  logic [CARD_ADDR_W-1:0] click_addr,
    output logic                   click_ready,
    input  logic [CARD_ADDR_W-1:0] view_addr,
    output card_view_t             view,
    output logic [PAIRS_W-1:0]     pairs_left,
    output logic                   game_over
);

    // Machine to queue
    logic                   fsm_cmd_valid;
    logic                   fsm_cmd_ready;
    card_cmd_t              fsm_cmd;

    // Queue to board
    logic                   brd_cmd_valid;
    logic                   brd_cmd_ready;
    card_cmd_t              brd_cmd;

    logic                   dealing;
    logic                   deal_done;
    logic [CARD_ADDR_W-1:0] lookup_addr;
    card_view_t             lookup_view;

    game_fsm u_fsm (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .deal_done   (deal_done),
        .click_valid (click_valid),
        .click_addr  (click_addr),
        .click_ready (click_ready),
        .lookup_view (lookup_view),
        .lookup_addr (lookup_addr),
        .cmd_valid   (fsm_cmd_valid),
        .cmd         (fsm_cmd),
        .cmd_ready   (fsm_cmd_ready),
        .dealing     (dealing),
        .pairs_left  (pairs_left),
        .game_over   (game_over)
    );

    card_cmd_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fsm_cmd_valid),
        .in_cmd    (fsm_cmd),
        .in_ready  (fsm_cmd_ready),
        .out_valid (brd_cmd_valid),
        .out_cmd   (brd_cmd),
        .out_ready (brd_cmd_ready)
    );

    card_board u_board (
        .clk         (clk),
        .rst         (rst),
        .dealing     (dealing),
        .deal_valid  (deal_valid),
        .deal_color  (deal_color),
        .deal_ready  (deal_ready),
        .deal_done   (deal_done),
        .cmd_valid   (brd_cmd_valid),
        .cmd         (brd_cmd),
        .cmd_ready   (brd_cmd_ready),
        .lookup_addr (lookup_addr),
        .lookup_view (lookup_view),
        .view_addr   (view_addr),
        .view        (view)
    );

endmodule

// File: memory_game_sva.sv
`timescale 1ns/100ps

module memory_game_sva
    import game_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      in_valid,
    input logic      in_ready,
    input logic      out_valid,
    input logic      out_ready,
    input card_cmd_t out_cmd
);

    logic                push_seen;
    logic                pop_seen;
    logic [FIFO_PTR_W:0] level;

    assign push_seen = in_valid && in_ready;
    assign pop_seen  = out_valid && out_ready;

    // Occupancy counted from the two handshakes
    always_ff @(posedge clk) begin
        if (rst) begin
            level <= '0;
        end else if (push_seen && !pop_seen) begin
            level <= level + 1'b1;
        end else if (pop_seen && !push_seen) begin
            level <= level - 1'b1;
        end
    end

    // Head entry waits for the board
    a_out_valid_held: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid)
        else $error("Queue output valid dropped without a transfer");

    a_out_cmd_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_cmd))
        else $error("Queue output command changed while stalled");

    a_full_blocks: assert property (@(posedge clk) disable iff (rst)
        level == (FIFO_PTR_W+1)'(FIFO_DEPTH) |-> !in_ready)
        else $error("Queue ready while full");

    // Empty once reset has been seen
    a_reset_empty: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("Queue output valid right after reset");

endmodule

bind card_cmd_fifo memory_game_sva u_sva (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_cmd   (out_cmd)
);

// File: tb_memory_game.sv
`timescale 1ns/100ps

module tb_memory_game
    import board_pkg::*, game_pkg::*;
();

    localparam int unsigned SEED = 32'h6949_1ede;
    localparam int NUM_GAMES     = 3;
    localparam int RANDOM_CLICKS = 24;
    // Worst case per click covers gap, judge, queue drain, show wait and a board read
    localparam int CLICK_CYCLES  = 8 + JUDGE_WAIT_CYCLES + 2 * FIFO_DEPTH + SHOW_WAIT_CYCLES
                                   + 2 * NUM_CARDS;
    localparam int GAME_CYCLES   = 4 * NUM_CARDS + (RANDOM_CLICKS + NUM_CARDS + 1) * CLICK_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * (NUM_GAMES * GAME_CYCLES + 8);

    logic                   clk;
    logic                   rst;
    logic                   start;
    logic                   deal_valid;
    logic [COLOR_W-1:0]     deal_color;
    logic                   deal_ready;
    logic                   click_valid;
    logic [CARD_ADDR_W-1:0] click_addr;
    logic                   click_ready;
    logic [CARD_ADDR_W-1:0] view_addr;
    card_view_t             view;
    logic [PAIRS_W-1:0]     pairs_left;
    logic                   game_over;

    // Game model
    card_status_t           m_status [NUM_CARDS];
    logic [COLOR_W-1:0]     m_color  [NUM_CARDS];
    int                     m_pairs;
    int                     first_addr;
    logic                   have_first;

    int                     tests = 0;
    int                     checks = 0;
    int                     errors = 0;
    int                     cycles = 0;

    memory_game_top UUT (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .deal_valid  (deal_valid),
        .deal_color  (deal_color),
        .deal_ready  (deal_ready),
        .click_valid (click_valid),
        .click_addr  (click_addr),
        .click_ready (click_ready),
        .view_addr   (view_addr),
        .view        (view),
        .pairs_left  (pairs_left),
        .game_over   (game_over)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without reaching the end", cycles);
            $display("Errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int base);
        tests++;
        $display("Test %-24s finished with %0d mismatches", name, errors - base);
    endtask

    // Hidden card with the same colour, or addr itself if none
    function automatic int find_partner(input int addr);
        int found;
        found = addr;
        for (int i = 0; i < NUM_CARDS; i++) begin
            if (i != addr && m_status[i] == CARD_HIDDEN && m_color[i] == m_color[addr]) begin
                found = i;
            end
        end
        return found;
    endfunction

    task automatic make_deal();
        logic [COLOR_W-1:0] c;
        int                 j;
        for (int p = 0; p < NUM_PAIRS; p++) begin
            c = COLOR_W'($urandom_range(0, (1 << COLOR_W) - 1));
            m_color[2*p]   = c;
            m_color[2*p+1] = c;
        end
        // Shuffle the card order in place
        for (int i = NUM_CARDS - 1; i > 0; i--) begin
            j          = $urandom_range(0, i);
            c          = m_color[i];
            m_color[i] = m_color[j];
            m_color[j] = c;
        end
        for (int i = 0; i < NUM_CARDS; i++) begin
            m_status[i] = CARD_HIDDEN;
        end
        m_pairs    = NUM_PAIRS;
        have_first = 1'b0;
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic deal_board();
        int i;
        i = 0;
        while (i < NUM_CARDS) begin
            @(negedge clk);
            deal_valid = 1'b1;
            deal_color = m_color[i];
            // Ready holds until the rising edge, so this colour is taken there
            if (deal_ready) begin
                i++;
            end
        end
        @(negedge clk);
        deal_valid = 1'b0;
    endtask

    task automatic verify_board();
        for (int i = 0; i < NUM_CARDS; i++) begin
            @(negedge clk);
            view_addr = CARD_ADDR_W'(i);
            #1;
            compare_value($sformatf("view.status[%0d]", i), 32'(view.status), 32'(m_status[i]));
            compare_value($sformatf("view.color[%0d]", i), 32'(view.color), 32'(m_color[i]));
        end
        compare_value("pairs_left", 32'(pairs_left), 32'(m_pairs));
        compare_value("game_over", 32'(game_over), 32'(m_pairs == 0));
        @(negedge clk);
    endtask

    task automatic click_card(input int addr);
        int gap;
        gap = $urandom_range(0, 3);
        @(negedge clk);
        repeat (gap) @(negedge clk);
        while (!click_ready) @(negedge clk);
        click_valid = 1'b1;
        click_addr  = CARD_ADDR_W'(addr);
        @(negedge clk);
        click_valid = 1'b0;
        if (m_status[addr] != CARD_HIDDEN) begin
            // Consumed without effect
            verify_board();
        end else if (!have_first) begin
            m_status[addr] = CARD_SHOWN;
            have_first     = 1'b1;
            first_addr     = addr;
            while (!click_ready) @(negedge clk);
            view_addr = CARD_ADDR_W'(addr);
            #1;
            compare_value("view.status", 32'(view.status), 32'(CARD_SHOWN));
            compare_value("view.color", 32'(view.color), 32'(m_color[addr]));
        end else begin
            have_first = 1'b0;
            if (m_color[first_addr] == m_color[addr]) begin
                m_status[first_addr] = CARD_REMOVED;
                m_status[addr]       = CARD_REMOVED;
                m_pairs--;
            end else begin
                m_status[first_addr] = CARD_HIDDEN;
                m_status[addr]       = CARD_HIDDEN;
            end
            while (!click_ready && !game_over) @(negedge clk);
            verify_board();
        end
    endtask

    task automatic play_game(input int game);
        int base;
        int addr;
        base = errors;
        make_deal();
        pulse_start();
        deal_board();
        while (!click_ready) @(negedge clk);
        verify_board();
        report_test($sformatf("game %0d deal", game), base);

        base = errors;
        for (int k = 0; k < RANDOM_CLICKS && m_pairs > 0; k++) begin
            // Now and then the player remembers where the partner lies
            if (have_first && $urandom_range(0, 3) == 0) begin
                addr = find_partner(first_addr);
            end else begin
                addr = $urandom_range(0, NUM_CARDS - 1);
            end
            click_card(addr);
        end
        report_test($sformatf("game %0d random clicks", game), base);

        base = errors;
        if (have_first) begin
            click_card(find_partner(first_addr));
        end
        for (int i = 0; i < NUM_CARDS; i++) begin
            if (m_status[i] == CARD_HIDDEN) begin
                click_card(i);
                click_card(find_partner(i));
            end
        end
        compare_value("game_over", 32'(game_over), 32'h1);
        report_test($sformatf("game %0d clear board", game), base);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int base;
        void'($urandom(SEED));
        rst         = 1'b1;
        start       = 1'b0;
        deal_valid  = 1'b0;
        deal_color  = '0;
        click_valid = 1'b0;
        click_addr  = '0;
        view_addr   = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        base = errors;
        compare_value("pairs_left", 32'(pairs_left), 32'(NUM_PAIRS));
        compare_value("game_over", 32'(game_over), 32'h0);
        compare_value("click_ready", 32'(click_ready), 32'h0);
        compare_value("deal_ready", 32'(deal_ready), 32'h0);
        report_test("reset state", base);

        for (int g = 0; g < NUM_GAMES; g++) begin
            play_game(g);
        end

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: compile.f
board_pkg.sv
game_pkg.sv
game_fsm.sv
card_cmd_fifo.sv
card_board.sv
memory_game_top.sv
memory_game_sva.sv
tb_memory_game.sv

// File: Bender.yml
package:
  name: memory_game

sources:
  - files:
      - board_pkg.sv
      - game_pkg.sv
      - game_fsm.sv
      - card_cmd_fifo.sv
      - card_board.sv
      - memory_game_top.sv
  - target: simulation
    files:
      - memory_game_sva.sv
      - tb_memory_game.sv
